//--- design/heap_defines.svh
/*
  Array heap geometry. Sets the number of arrays, the slots per array,
  the element width and the width of an action code.
*/
`ifndef HEAP_DEFINES_SVH
`define HEAP_DEFINES_SVH

// ------------------------------
// Base widths
// ------------------------------
`define HEAP_ADDRESS_BITS 2   // Bits in an array id
`define HEAP_INDEX_BITS   2   // Bits in an element index
`define HEAP_DATA_BITS    12  // Element width
`define HEAP_ACTION_BITS  8   // Action code width

// ------------------------------
// Derived counts
// ------------------------------
`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)  // Arrays in the heap
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)    // Slots per array

`endif

//--- design/heapPkg.sv
/*
  Array heap types. Action and error encodings plus the id, index,
  size and element types shared by the heap blocks.
*/
`default_nettype none

`include "heap_defines.svh"

package heapPkg;

  typedef enum logic [`HEAP_ACTION_BITS-1:0] {
    idle      = 0,   // No-op
    heapReset = 1,   // Drop every allocation
    write     = 2,
    read      = 3,
    size      = 4,
    push      = 14,
    pop       = 15,
    alloc     = 18,  // Freed array first, then a new one
    free      = 19,
    add       = 20,  // Returns new value
    addAfter  = 21,  // Returns old value
    subtract  = 22,
    orOp      = 28,
    xorOp     = 29,
    andOp     = 30
  } actionCode;

  typedef enum logic [2:0] {
    none,
    notAllocated,   // Not handed out since last reset
    freed,          // Handed out, then freed
    outOfBounds,
    full,
    empty,
    outOfMemory
  } errorCode;

  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayId;
  typedef logic [`HEAP_INDEX_BITS-1:0]   slotIndex;
  typedef logic [`HEAP_INDEX_BITS:0]     arraySize;    // Holds full length too
  typedef logic [`HEAP_DATA_BITS-1:0]    elementData;

endpackage

`default_nettype wire

//--- design/heapRequestIf.sv
/*
  Heap request bundle. One action with its array, index and data,
  fanned out from the top level to the allocator and the store.
*/
`timescale 1ns/1ns
`default_nettype none

interface heapRequestIf;
  import heapPkg::*;

  actionCode  action;  // One-cycle action level
  arrayId     array;   // Target array
  slotIndex   index;   // Element within array
  elementData dataIn;  // Operand or write data

  modport allocatorPort (
    input action, array, index     // Bookkeeping needs no data
  );

  modport storePort (
    input action, array, index, dataIn
  );

endinterface

`default_nettype wire

//--- design/arrayAllocator.sv
/*
  Array allocator. Tracks handed-out arrays, the free stack and array
  sizes, judges legality of every action and steers the element store.
*/
`timescale 1ns/1ns
`default_nettype none

`include "heap_defines.svh"

module arrayAllocator (
  input  logic                          clock,
  input  logic                          reset,
  heapRequestIf.allocatorPort           request,
  output logic                          commit,      // Store writes this cycle
  output heapPkg::slotIndex             slot,        // Element for the store
  output heapPkg::arraySize             allocValue,  // Id from alloc or size
  output heapPkg::errorCode             allocError,
  output logic                          accepted     // Known non-idle action taken
);
  import heapPkg::*;

  localparam logic [`HEAP_ADDRESS_BITS:0] arrayCount = `HEAP_ARRAYS;
  localparam arraySize maxSize = arraySize'(`HEAP_ARRAY_LENGTH);

  // ------------------------------
  // Bookkeeping state
  // ------------------------------
  logic [`HEAP_ADDRESS_BITS:0]   allocatedCount;             // New arrays handed out
  logic [`HEAP_ARRAYS-1:0]       allocated;                  // Live flag per array
  arrayId                        freeStack [`HEAP_ARRAYS];   // Ids ready for reuse
  logic [`HEAP_ADDRESS_BITS:0]   freeTop;                    // Entries on free stack
  arraySize                      sizes [`HEAP_ARRAYS];       // Current length per array

  arraySize curSize;
  logic     neverHanded;
  logic     inBounds;
  errorCode accessError;   // Writeable check
  errorCode readError;     // Readable check
  errorCode nextError;
  logic     known;
  arrayId   newId;

  // ------------------------------
  // Legality and store steering
  // ------------------------------
  always_comb begin
    curSize     = sizes[request.array];
    neverHanded = {1'b0, request.array} >= allocatedCount;
    inBounds    = arraySize'(request.index) < curSize;

    // Priority: notAllocated, then freed
    if (neverHanded) begin
      accessError = notAllocated;
    end else if (!allocated[request.array]) begin
      accessError = freed;
    end else begin
      accessError = none;
    end
    readError = (accessError != none) ? accessError : (inBounds ? none : outOfBounds);

    // Reuse beats fresh allocation
    newId = (freeTop != '0) ? freeStack[arrayId'(freeTop - 1'b1)] :
                              arrayId'(allocatedCount);

    known     = 1'b1;
    nextError = none;
    commit    = 1'b0;
    slot      = request.index;   // Index for most actions
    case (request.action)
      heapReset: nextError = none;
      alloc: begin
        if (freeTop == '0 && allocatedCount == arrayCount) nextError = outOfMemory;
      end
      free, size: nextError = accessError;
      write: begin
        nextError = accessError;
        commit    = (accessError == none);
      end
      read: nextError = readError;
      push: begin
        nextError = (accessError != none) ? accessError :
                    (curSize == maxSize) ? full : none;
        slot      = slotIndex'(curSize);            // Next free slot
        commit    = (nextError == none);
      end
      pop: begin
        nextError = (accessError != none) ? accessError :
                    (curSize == '0) ? empty : none;
        slot      = slotIndex'(curSize - 1'b1);     // Last element
      end
      add, addAfter, subtract, orOp, xorOp, andOp: begin
        nextError = readError;
        commit    = (readError == none);
      end
      default: known = 1'b0;   // Idle and unused codes
    endcase
  end

  // ------------------------------
  // State update at the sampling edge
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocatedCount <= '0;
      freeTop        <= '0;
      allocated      <= '0;
      accepted       <= 1'b0;
      allocError     <= none;
    end else begin
      accepted   <= known;
      allocError <= nextError;
      if (known && nextError == none) begin
        case (request.action)
          heapReset: begin
            allocatedCount <= '0;
            freeTop        <= '0;
            allocated      <= '0;
          end
          alloc: begin
            if (freeTop != '0) freeTop <= freeTop - 1'b1;   // Pop free stack
            else allocatedCount <= allocatedCount + 1'b1;
            allocated[newId] <= 1'b1;
            sizes[newId]     <= '0;                          // Starts empty
            allocValue       <= arraySize'(newId);
          end
          free: begin
            freeStack[arrayId'(freeTop)] <= request.array;
            freeTop                      <= freeTop + 1'b1;
            allocated[request.array]     <= 1'b0;
          end
          write: begin
            if (!inBounds) sizes[request.array] <= arraySize'(request.index) + 1'b1;
          end
          size: allocValue <= curSize;
          push: sizes[request.array] <= curSize + 1'b1;
          pop:  sizes[request.array] <= curSize - 1'b1;
          default: ;   // Element actions leave bookkeeping alone
        endcase
      end
    end
  end

  // Double free is caught, so freed ids never outnumber handed-out ones
  freeStackBound: assert property (@(posedge clock) disable iff (reset)
    freeTop <= allocatedCount && allocatedCount <= arrayCount);

endmodule

`default_nettype wire

//--- design/elementStore.sv
/*
  Element store. Holds every array's elements, applies the arithmetic
  and logic actions in place and registers the value each one returns.
*/
`timescale 1ns/1ns
`default_nettype none

`include "heap_defines.svh"

module elementStore (
  input  logic                 clock,
  heapRequestIf.storePort      request,
  input  logic                 commit,      // Legal element write
  input  heapPkg::slotIndex    slot,        // Element chosen by allocator
  output heapPkg::elementData  storeValue,  // Value returned by the action
  output heapPkg::actionCode   lastAction   // Action seen last edge
);
  import heapPkg::*;

  elementData elements [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];   // Fixed block per array

  elementData current;    // Element before the action
  elementData newValue;   // Element after the action
  elementData result;

  // ------------------------------
  // Element datapath
  // ------------------------------
  always_comb begin
    current = elements[request.array][slot];
    case (request.action)
      write, push:     newValue = request.dataIn;
      add, addAfter:   newValue = current + request.dataIn;   // Wraps at data width
      subtract:        newValue = current - request.dataIn;
      orOp:            newValue = current | request.dataIn;
      xorOp:           newValue = current ^ request.dataIn;
      andOp:           newValue = current & request.dataIn;
      default:         newValue = current;
    endcase

    case (request.action)
      write:               result = request.dataIn;
      read, pop, addAfter: result = current;   // Old contents
      default:             result = newValue;
    endcase
  end

  always_ff @(posedge clock) begin
    if (commit) elements[request.array][slot] <= newValue;
    storeValue <= result;
    lastAction <= request.action;
  end

  // Allocator must never let a non-writing action reach memory
  noStrayWrite: assert property (@(posedge clock)
    !(commit && (request.action inside {read, size, alloc, free})));

endmodule

`default_nettype wire

//--- design/responseMerge.sv
/*
  Response stage. Combines allocator and store results into the
  registered out value, error code and one-cycle done pulse.
*/
`timescale 1ns/1ns
`default_nettype none

module responseMerge (
  input  logic                 clock,
  input  logic                 reset,
  input  heapPkg::actionCode   lastAction,  // Action taken last edge
  input  logic                 accepted,
  input  heapPkg::arraySize    allocValue,
  input  heapPkg::errorCode    allocError,
  input  heapPkg::elementData  storeValue,
  output heapPkg::elementData  dataOut,
  output heapPkg::errorCode    error,
  output logic                 done
);
  import heapPkg::*;

  always_ff @(posedge clock) begin
    if (reset) begin
      dataOut <= '0;
      error   <= none;
      done    <= 1'b0;
    end else begin
      done <= accepted;   // One pulse per accepted action
      if (accepted) begin
        error <= allocError;
        if (allocError == none) begin   // Out holds on error
          case (lastAction)
            alloc, size: dataOut <= elementData'(allocValue);
            write, read, pop, add, addAfter, subtract, orOp, xorOp, andOp:
              dataOut <= storeValue;
            default: ;   // free, push and heapReset keep out
          endcase
        end
      end
    end
  end

  // ------------------------------
  // Pulse check
  // ------------------------------
  // Allocator and store registered the same real action
  acceptedMatchesAction: assert property (@(posedge clock) disable iff (reset)
    accepted |-> lastAction != idle);

endmodule

`default_nettype wire

//--- design/arrayHeap.sv
/*
  Pipelined array heap top. Allocator and element store act side by
  side on each request and the response stage reports two cycles later.
*/
`timescale 1ns/1ns
`default_nettype none

module arrayHeap (
  input  logic                 clock,
  input  logic                 reset,
  input  heapPkg::actionCode   action,
  input  heapPkg::arrayId      array,
  input  heapPkg::slotIndex    index,
  input  heapPkg::elementData  dataIn,
  output heapPkg::elementData  dataOut,
  output heapPkg::errorCode    error,
  output logic                 done
);
  import heapPkg::*;

  heapRequestIf requestBus ();   // Shared request to inner blocks

  logic       commit;
  slotIndex   slot;
  arraySize   allocValue;
  errorCode   allocError;
  logic       accepted;
  elementData storeValue;
  actionCode  lastAction;

  assign requestBus.action = action;
  assign requestBus.array  = array;
  assign requestBus.index  = index;
  assign requestBus.dataIn = dataIn;

  // ------------------------------
  // Bookkeeping and storage
  // ------------------------------
  arrayAllocator allocator (
    .clock      (clock),
    .reset      (reset),
    .request    (requestBus.allocatorPort),
    .commit     (commit),
    .slot       (slot),
    .allocValue (allocValue),
    .allocError (allocError),
    .accepted   (accepted)
  );

  elementStore store (
    .clock      (clock),
    .request    (requestBus.storePort),
    .commit     (commit),
    .slot       (slot),
    .storeValue (storeValue),
    .lastAction (lastAction)
  );

  responseMerge merge (
    .clock      (clock),
    .reset      (reset),
    .lastAction (lastAction),
    .accepted   (accepted),
    .allocValue (allocValue),
    .allocError (allocError),
    .storeValue (storeValue),
    .dataOut    (dataOut),
    .error      (error),
    .done       (done)
  );

endmodule

`default_nettype wire

//--- verif/arrayHeapTb.sv
/*
  Array heap testbench. Directed and random actions checked against a
  behavioral model, one expected result per done pulse, in order.
*/
`timescale 1ns/1ns
`default_nettype none

`include "heap_defines.svh"

module arrayHeapTb;
  import heapPkg::*;

  localparam logic [31:0] seed = 32'h91f9bd48;
  localparam int settleTimeout = 20;    // Cycles to drain pending results
  localparam int opCount       = 400;   // Random back-to-back actions

  typedef struct packed {
    logic       known;   // Action gets a done pulse
    errorCode   err;
    elementData out;
  } expectation;

  logic       clock;
  logic       reset;
  actionCode  action;
  arrayId     array;
  slotIndex   index;
  elementData dataIn;
  elementData dataOut;
  errorCode   error;
  logic       done;

  // ------------------------------
  // Model state
  // ------------------------------
  int         handedOut;                                       // New ids given so far
  bit         modelAllocated [`HEAP_ARRAYS];
  int         freeStack [`HEAP_ARRAYS];
  int         freeTop;
  int         modelSizes [`HEAP_ARRAYS];
  elementData modelElems [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  elementData lastOut;                                         // Out holds on error

  expectation expectQueue [$];
  string      nameQueue [$];

  logic [7:0] randomCodes [16] = '{2, 3, 4, 14, 15, 18, 18, 19, 20, 21, 22, 28, 29, 30,
                                   0, 7};   // Idle and an unused code too

  arrayHeap uut (
    .clock   (clock),
    .reset   (reset),
    .action  (action),
    .array   (array),
    .index   (index),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .error   (error),
    .done    (done)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;   // 20 ns period
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic expectation predictResult(input actionCode act, input int arr,
                                               input int idx, input elementData data);
    expectation e;
    errorCode   acc;
    errorCode   readErr;
    int         sz;
    int         id;
    elementData old;
    elementData nv;
    e.known = 1'b1;
    e.err   = none;
    sz      = modelSizes[arr];
    if (arr >= handedOut) acc = notAllocated;
    else if (!modelAllocated[arr]) acc = freed;
    else acc = none;
    readErr = (acc != none) ? acc : ((idx >= sz) ? outOfBounds : none);
    case (act)
      heapReset: begin
        handedOut = 0;
        freeTop   = 0;
        for (int a = 0; a < `HEAP_ARRAYS; a++) modelAllocated[a] = 1'b0;
      end
      alloc: begin
        if (freeTop == 0 && handedOut == `HEAP_ARRAYS) begin
          e.err = outOfMemory;
        end else begin
          if (freeTop > 0) begin   // Reuse freed id first
            freeTop--;
            id = freeStack[freeTop];
          end else begin
            id = handedOut;
            handedOut++;
          end
          modelAllocated[id] = 1'b1;
          modelSizes[id]     = 0;
          lastOut            = elementData'(id);
        end
      end
      free: begin
        e.err = acc;
        if (acc == none) begin
          freeStack[freeTop]  = arr;
          freeTop++;
          modelAllocated[arr] = 1'b0;
        end
      end
      size: begin
        e.err = acc;
        if (acc == none) lastOut = elementData'(sz);
      end
      write: begin
        e.err = acc;
        if (acc == none) begin
          modelElems[arr][idx] = data;
          if (idx >= sz) modelSizes[arr] = idx + 1;   // Extends past end
          lastOut = data;
        end
      end
      read: begin
        e.err = readErr;
        if (readErr == none) lastOut = modelElems[arr][idx];
      end
      push: begin
        e.err = (acc != none) ? acc : ((sz == `HEAP_ARRAY_LENGTH) ? full : none);
        if (e.err == none) begin
          modelElems[arr][sz] = data;
          modelSizes[arr]     = sz + 1;
        end
      end
      pop: begin
        e.err = (acc != none) ? acc : ((sz == 0) ? empty : none);
        if (e.err == none) begin
          lastOut         = modelElems[arr][sz - 1];
          modelSizes[arr] = sz - 1;
        end
      end
      add, addAfter, subtract, orOp, xorOp, andOp: begin
        e.err = readErr;
        if (readErr == none) begin
          old = modelElems[arr][idx];
          case (act)
            add, addAfter: nv = old + data;   // 12-bit wrap
            subtract:      nv = old - data;
            orOp:          nv = old | data;
            xorOp:         nv = old ^ data;
            default:       nv = old & data;
          endcase
          modelElems[arr][idx] = nv;
          lastOut = (act == addAfter) ? old : nv;
        end
      end
      default: e.known = 1'b0;   // No done pulse
    endcase
    e.out = lastOut;
    return e;
  endfunction

  task automatic clearModel();
    handedOut = 0;
    freeTop   = 0;
    lastOut   = '0;
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      modelAllocated[a] = 1'b0;
      modelSizes[a]     = 0;
    end
  endtask

  // ------------------------------
  // Stimulus and checking
  // ------------------------------
  task automatic compareValue(input string testName, input int expected, input int actual);
    if (expected != actual) begin
      $display("Mismatch %s expected %0h actual %0h", testName, expected, actual);
      $display("Test failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic issueAction(input actionCode act, input int arr, input int idx,
                             input elementData data, input string name);
    expectation e;
    @(posedge clock);
    #1;
    action = act;
    array  = arrayId'(arr);
    index  = slotIndex'(idx);
    dataIn = data;
    e = predictResult(act, arr, idx, data);
    if (e.known) begin
      expectQueue.push_back(e);
      nameQueue.push_back(name);
    end
  endtask

  task automatic settle();
    int cycles;
    cycles = 0;
    @(posedge clock);
    #1 action = idle;
    while (expectQueue.size() != 0) begin   // Drain in-flight results
      if (cycles == settleTimeout) begin
        $display("Timed out waiting for done");
        $display("Test failed");
        $fatal(1, "No done pulse in time");
      end
      @(posedge clock);
      cycles++;
    end
  endtask

  initial begin : resultCheck
    expectation e;
    string      name;
    forever begin
      @(negedge clock);   // Outputs stable mid-cycle
      if (!reset && done) begin
        if (expectQueue.size() == 0) begin
          $display("Done pulsed with no action pending");
          $display("Test failed");
          $fatal(1, "Unexpected done");
        end
        e    = expectQueue.pop_front();
        name = nameQueue.pop_front();
        compareValue({name, " error"}, int'(e.err), int'(error));
        compareValue({name, " dataOut"}, int'(e.out), int'(dataOut));
      end
    end
  end

  initial begin
    int code;
    reset  = 1'b1;
    action = idle;
    array  = '0;
    index  = '0;
    dataIn = '0;
    void'($urandom(seed));
    clearModel();
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;

    // Allocation order, exhaustion, reuse
    for (int a = 0; a < `HEAP_ARRAYS; a++) issueAction(alloc, 0, 0, '0, "allocOrder");
    issueAction(alloc, 0, 0, '0, "outOfMemory");
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
        issueAction(write, a, i, elementData'((a * 4 + i) * 293 + 57), "fill");
      end
    end
    issueAction(free, 2, 0, '0, "freeOne");
    issueAction(alloc, 0, 0, '0, "reuseFreed");
    settle();

    // Write, read, size and bounds
    issueAction(heapReset, 0, 0, '0, "heapReset");
    issueAction(alloc, 0, 0, '0, "allocFresh");
    issueAction(write, 0, 0, 12'h5a3, "writeRead");
    issueAction(read, 0, 0, '0, "writeRead");
    issueAction(write, 0, 2, 12'h0c7, "writePastEnd");
    issueAction(size, 0, 0, '0, "sizeAfterWrite");
    issueAction(read, 0, 3, '0, "readOutOfBounds");
    issueAction(read, 0, 1, '0, "readInside");
    settle();

    // Push to full, pop to empty
    issueAction(alloc, 0, 0, '0, "allocStack");
    for (int i = 0; i <= `HEAP_ARRAY_LENGTH; i++) begin
      issueAction(push, 1, 0, elementData'(12'h100 + i * 17), "pushFull");
    end
    issueAction(size, 1, 0, '0, "sizeFull");
    for (int i = 0; i <= `HEAP_ARRAY_LENGTH; i++) issueAction(pop, 1, 0, '0, "popOrder");
    settle();

    // In-place arithmetic and logic
    issueAction(write, 0, 1, 12'hff0, "arithSetup");
    issueAction(add, 0, 1, 12'h020, "addWrap");
    issueAction(addAfter, 0, 1, 12'h005, "addAfter");
    issueAction(subtract, 0, 1, 12'h020, "subtractWrap");
    issueAction(orOp, 0, 1, 12'h30c, "orOp");
    issueAction(xorOp, 0, 1, 12'ha5a, "xorOp");
    issueAction(andOp, 0, 1, 12'h3c3, "andOp");
    issueAction(read, 0, 1, '0, "readAfterArith");
    settle();

    // Error cases
    issueAction(read, 3, 0, '0, "neverAllocated");
    issueAction(free, 1, 0, '0, "freeOnce");
    issueAction(free, 1, 0, '0, "doubleFree");
    issueAction(heapReset, 0, 0, '0, "heapReset");
    for (int a = 0; a < `HEAP_ARRAYS; a++) issueAction(read, a, 0, '0, "afterHeapReset");
    settle();

    // Random back-to-back stream
    for (int n = 0; n < opCount; n++) begin
      code = int'(randomCodes[$urandom_range(0, 15)]);
      if ($urandom_range(0, 63) == 0) code = 1;   // Rare heapReset
      issueAction(actionCode'(code), int'($urandom_range(0, `HEAP_ARRAYS - 1)),
                  int'($urandom_range(0, `HEAP_ARRAY_LENGTH - 1)),
                  elementData'($urandom()), "randomStream");
    end
    settle();
    repeat (3) @(posedge clock);   // Catch any stray done

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- arrayHeap.f
+incdir+design
design/heapPkg.sv
design/heapRequestIf.sv
design/arrayAllocator.sv
design/elementStore.sv
design/responseMerge.sv
design/arrayHeap.sv
verif/arrayHeapTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build the array heap testbench with Verilator and run it.
# The exit status is the simulator's, so a failing run fails the script.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f arrayHeap.f \
  --top-module arrayHeapTb \
  -o simArrayHeap
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/simArrayHeap
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished with status 0"
exit 0
